// File: debug_pkg.sv
//******************************
// Shared widths for the serial debug line
// ASCII codes used by the formatters
//******************************

`default_nettype none

package debug_pkg;

  // Line geometry
  parameter int CHAR_W    = 8;
  // Characters per line, CR included
  parameter int MSG_CHARS = 10;

  // Timestamp tick count width
  parameter int STAMP_W      = 14;
  // Decimal digits for the largest count, 16383
  parameter int STAMP_DIGITS = 5;

  // Digit and letter bases for hex and decimal text
  parameter logic [CHAR_W-1:0] ASCII_ZERO = 8'h30;
  parameter logic [CHAR_W-1:0] ASCII_A    = 8'h41;

  // Separators
  parameter logic [CHAR_W-1:0] ASCII_DOT   = 8'h2e;
  parameter logic [CHAR_W-1:0] ASCII_SPACE = 8'h20;
  // Line terminator, no line feed
  parameter logic [CHAR_W-1:0] ASCII_CR    = 8'h0d;

endpackage

`default_nettype wire

// File: stamp_counter.sv
//******************************
// Timestamp tick divider
// Wrapping tick counter
//******************************

`timescale 1ns/100ps
`default_nettype none

module stamp_counter #(
  parameter int STEP = 5000000
) (
  input  wire                             clk_debug,
  input  wire                             rst,
  output logic                            tick,
  output logic [debug_pkg::STAMP_W-1:0]   count
);

  // Down-counter width, at least one bit
  localparam int DIV_W = (STEP > 1) ? $clog2(STEP) : 1;

  logic [DIV_W-1:0] div_cnt;

  always_ff @(posedge clk_debug) begin
    if (rst) begin
      div_cnt <= DIV_W'(STEP - 1);
      tick    <= 1'b0;
      count   <= '0;
    end else if (div_cnt == '0) begin
      // Period done, reload and stamp
      div_cnt <= DIV_W'(STEP - 1);
      tick    <= 1'b1;
      // Count wraps at 2**STAMP_W
      count   <= count + 1'b1;
    end else begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: bin2bcd.sv
//******************************
// Sequential binary to BCD converter
// Shift-and-add-3, one bit per cycle
//******************************

`timescale 1ns/100ps
`default_nettype none

module bin2bcd (
  input  wire                                    clk_debug,
  input  wire                                    rst,
  input  wire                                    start,
  input  wire  [debug_pkg::STAMP_W-1:0]          bin,
  output logic [debug_pkg::STAMP_DIGITS*4-1:0]   bcd,
  output logic                                   done
);

  localparam int BCD_W  = debug_pkg::STAMP_DIGITS * 4;
  localparam int WORK_W = BCD_W + debug_pkg::STAMP_W;
  localparam int STEP_W = $clog2(debug_pkg::STAMP_W + 1);

  // BCD digits above, remaining binary below
  logic [WORK_W-1:0] work;
  logic [WORK_W-1:0] step_val;
  logic [STEP_W-1:0] steps_left;
  logic              active;

  // Add three to every digit of five or more
  function automatic logic [BCD_W-1:0] adjust(input logic [BCD_W-1:0] d);
    logic [BCD_W-1:0] r;
    r = d;
    for (int i = 0; i < debug_pkg::STAMP_DIGITS; i++) begin
      if (r[4*i +: 4] >= 4'd5) begin
        r[4*i +: 4] = r[4*i +: 4] + 4'd3;
      end
    end
    return r;
  endfunction

  // One conversion step
  assign step_val = {adjust(work[WORK_W-1 -: BCD_W]), work[debug_pkg::STAMP_W-1:0]} << 1;

  always_ff @(posedge clk_debug) begin
    if (rst) begin
      active     <= 1'b0;
      steps_left <= '0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // New value restarts any running conversion
        active     <= 1'b1;
        steps_left <= STEP_W'(debug_pkg::STAMP_W);
      end else if (active) begin
        steps_left <= steps_left - 1'b1;
        if (steps_left == STEP_W'(1)) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // Datapath, no reset
  always_ff @(posedge clk_debug) begin
    if (start) begin
      work <= {{BCD_W{1'b0}}, bin};
    end else if (active) begin
      work <= step_val;
      // Result held until next start
      if (steps_left == STEP_W'(1)) bcd <= step_val[WORK_W-1 -: BCD_W];
    end
  end

endmodule

`default_nettype wire

// File: status_hex.sv
//******************************
// Board status capture
// Byte to two ASCII hex characters
//******************************

`timescale 1ns/100ps
`default_nettype none

module status_hex (
  input  wire                               clk_debug,
  input  wire                               rst,
  input  wire                               capture,
  input  wire  [7:0]                        status,
  output logic [2*debug_pkg::CHAR_W-1:0]    hex_chars,
  output logic                              ready
);

  // Nibble to upper-case hex digit
  function automatic logic [debug_pkg::CHAR_W-1:0] hex_char(input logic [3:0] n);
    if (n < 4'd10) return debug_pkg::ASCII_ZERO + {4'b0000, n};
    return debug_pkg::ASCII_A + {4'b0000, n - 4'd10};
  endfunction

  always_ff @(posedge clk_debug) begin
    if (rst) ready <= 1'b0;
    else     ready <= capture;
  end

  // High nibble first, characters held until next capture
  always_ff @(posedge clk_debug) begin
    if (capture) begin
      hex_chars <= {hex_char(status[7:4]), hex_char(status[3:0])};
    end
  end

endmodule

`default_nettype wire

// File: msg_assembler.sv
//******************************
// Debug line assembly
// Waits for stamp and status, holds line
// until the transmitter is free
//******************************

`timescale 1ns/100ps
`default_nettype none

module msg_assembler (
  input  wire                                              clk_debug,
  input  wire                                              rst,
  input  wire  [debug_pkg::STAMP_DIGITS*4-1:0]             bcd,
  input  wire                                              bcd_done,
  input  wire  [2*debug_pkg::CHAR_W-1:0]                   hex_chars,
  input  wire                                              hex_ready,
  input  wire                                              busy,
  output logic                                             send,
  output logic [debug_pkg::MSG_CHARS*debug_pkg::CHAR_W-1:0] data
);

  localparam int MSG_W = debug_pkg::MSG_CHARS * debug_pkg::CHAR_W;

  logic             bcd_got;
  logic             hex_got;
  logic             both_ready;
  logic             pending;
  logic [MSG_W-1:0] line_next;

  // BCD digit to ASCII
  function automatic logic [debug_pkg::CHAR_W-1:0] dig(input logic [3:0] d);
    return debug_pkg::ASCII_ZERO + {4'b0000, d};
  endfunction

  // A strobe in this cycle counts as already seen
  assign both_ready = (bcd_got | bcd_done) & (hex_got | hex_ready);

  // "dddd.d hh\r", first character in the top byte
  assign line_next = {dig(bcd[19:16]), dig(bcd[15:12]), dig(bcd[11:8]), dig(bcd[7:4]),
                      debug_pkg::ASCII_DOT, dig(bcd[3:0]), debug_pkg::ASCII_SPACE,
                      hex_chars, debug_pkg::ASCII_CR};

  // Hand over as soon as the UART is idle
  assign send = pending & ~busy;

  always_ff @(posedge clk_debug) begin
    if (rst) begin
      bcd_got <= 1'b0;
      hex_got <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (both_ready) begin
        bcd_got <= 1'b0;
        hex_got <= 1'b0;
        // Newer line replaces one still waiting
        pending <= 1'b1;
      end else begin
        bcd_got <= bcd_got | bcd_done;
        hex_got <= hex_got | hex_ready;
        if (send) pending <= 1'b0;
      end
    end
  end

  // Line buffer, read by the UART on send
  always_ff @(posedge clk_debug) begin
    if (both_ready) data <= line_next;
  end

endmodule

`default_nettype wire

// File: serial_debug.sv
//******************************
// 8N1 UART transmitter for one debug line
// First character first, LSB first
//******************************

`timescale 1ns/100ps
`default_nettype none

module serial_debug #(
  parameter int CLK_PER_BIT = 434
) (
  input  wire                                              clk_debug,
  input  wire                                              rst,
  input  wire                                              send,
  input  wire  [debug_pkg::MSG_CHARS*debug_pkg::CHAR_W-1:0] data,
  output logic                                             busy,
  output logic                                             tx
);

  localparam int MSG_W  = debug_pkg::MSG_CHARS * debug_pkg::CHAR_W;
  localparam int CLK_W  = (CLK_PER_BIT > 1) ? $clog2(CLK_PER_BIT) : 1;
  localparam int CHAR_IW = (debug_pkg::MSG_CHARS > 1) ? $clog2(debug_pkg::MSG_CHARS) : 1;

  logic [MSG_W-1:0]              line_buf;
  logic [debug_pkg::CHAR_W-1:0]  cur_char;
  logic [CLK_W-1:0]              clk_cnt;
  // 0 start, 1 to 8 data, 9 stop
  logic [3:0]                    bit_idx;
  logic [CHAR_IW-1:0]            char_idx;

  // Character on the wire sits in the top byte
  assign cur_char = line_buf[MSG_W-1 -: debug_pkg::CHAR_W];

  always_ff @(posedge clk_debug) begin
    if (rst) begin
      busy     <= 1'b0;
      tx       <= 1'b1;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      char_idx <= '0;
    end else if (!busy) begin
      if (send) begin
        // Start bit of the first character right away
        busy     <= 1'b1;
        tx       <= 1'b0;
        clk_cnt  <= '0;
        bit_idx  <= '0;
        char_idx <= '0;
      end
    end else if (clk_cnt == CLK_W'(CLK_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_idx == 4'd9) begin
        if (char_idx == CHAR_IW'(debug_pkg::MSG_CHARS - 1)) begin
          // Last stop bit done, line idle
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          // Next character follows with no gap
          char_idx <= char_idx + 1'b1;
          bit_idx  <= '0;
          tx       <= 1'b0;
        end
      end else begin
        bit_idx <= bit_idx + 1'b1;
        // Data bit bit_idx, then stop
        tx      <= (bit_idx == 4'd8) ? 1'b1 : cur_char[bit_idx[2:0]];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Line buffer, moves up one character per stop bit
  always_ff @(posedge clk_debug) begin
    if (!busy && send) begin
      line_buf <= data;
    end else if (busy && clk_cnt == CLK_W'(CLK_PER_BIT - 1) && bit_idx == 4'd9) begin
      line_buf <= line_buf << debug_pkg::CHAR_W;
    end
  end

endmodule

`default_nettype wire

// File: avionics_debug.sv
//******************************
// Serial debug subsystem top level
// Stamp, converters, assembler, UART
//******************************

`timescale 1ns/100ps
`default_nettype none

module avionics_debug #(
  parameter int STEP        = 5000000,
  parameter int CLK_PER_BIT = 434
) (
  input  wire        clk_debug,
  input  wire        rst,
  input  wire  [7:0] status,
  output logic       tx,
  output logic       busy
);

  logic                                              tick;
  logic [debug_pkg::STAMP_W-1:0]                     count;
  logic [debug_pkg::STAMP_DIGITS*4-1:0]              bcd;
  logic                                              bcd_done;
  logic [2*debug_pkg::CHAR_W-1:0]                    hex_chars;
  logic                                              hex_ready;
  logic                                              send;
  logic [debug_pkg::MSG_CHARS*debug_pkg::CHAR_W-1:0] data;

  // Timestamp source
  stamp_counter #(.STEP(STEP)) u_stamp (
    .clk_debug(clk_debug), .rst(rst), .tick(tick), .count(count));

  // Both converters start on the same tick
  bin2bcd u_bin2bcd (
    .clk_debug(clk_debug), .rst(rst), .start(tick), .bin(count),
    .bcd(bcd), .done(bcd_done));

  status_hex u_status_hex (
    .clk_debug(clk_debug), .rst(rst), .capture(tick), .status(status),
    .hex_chars(hex_chars), .ready(hex_ready));

  msg_assembler u_assembler (
    .clk_debug(clk_debug), .rst(rst), .bcd(bcd), .bcd_done(bcd_done),
    .hex_chars(hex_chars), .hex_ready(hex_ready), .busy(busy),
    .send(send), .data(data));

  // Debug pin driver
  serial_debug #(.CLK_PER_BIT(CLK_PER_BIT)) u_serial (
    .clk_debug(clk_debug), .rst(rst), .send(send), .data(data),
    .busy(busy), .tx(tx));

endmodule

`default_nettype wire

// File: avionics_debug_checker.sv
//******************************
// Bound protocol checker
// Reset values, idle level, busy length
//******************************

`timescale 1ns/100ps
`default_nettype none

module avionics_debug_checker #(
  parameter int CLK_PER_BIT = 4
) (
  input wire clk_debug,
  input wire rst,
  input wire tick,
  input wire bcd_done,
  input wire hex_ready,
  input wire send,
  input wire busy,
  input wire tx
);

  // Ten bit periods per character
  localparam int LINE_CYCLES = debug_pkg::MSG_CHARS * 10 * CLK_PER_BIT;

  int busy_len;
  int fail_count = 0;

  // Cycles busy has been high without a break
  always_ff @(posedge clk_debug) begin
    if (rst || !busy) begin
      busy_len <= 0;
    end else begin
      busy_len <= busy_len + 1;
    end
  end

  // Quiet strobes and outputs once reset has been seen
  reset_state: assert property (@(posedge clk_debug)
    rst |=> (tx && !busy && !tick && !bcd_done && !hex_ready && !send))
    else begin
      $error("Outputs not idle after reset");
      fail_count++;
    end

  // Line idles high between lines
  idle_high: assert property (@(posedge clk_debug) disable iff (rst) !busy |-> tx)
    else begin
      $error("tx low while busy is low");
      fail_count++;
    end

  send_starts: assert property (@(posedge clk_debug) disable iff (rst) send |=> busy)
    else begin
      $error("busy did not follow send");
      fail_count++;
    end

  busy_from_send: assert property (@(posedge clk_debug) disable iff (rst)
    $rose(busy) |-> $past(send))
    else begin
      $error("busy rose without send");
      fail_count++;
    end

  // Busy spans exactly one full line
  line_length: assert property (@(posedge clk_debug) disable iff (rst)
    $fell(busy) |-> (busy_len == LINE_CYCLES))
    else begin
      $error("busy held %0d cycles, expected %0d", busy_len, LINE_CYCLES);
      fail_count++;
    end

endmodule

bind avionics_debug avionics_debug_checker #(.CLK_PER_BIT(CLK_PER_BIT)) u_checker (
  .clk_debug(clk_debug), .rst(rst), .tick(tick), .bcd_done(bcd_done),
  .hex_ready(hex_ready), .send(send), .busy(busy), .tx(tx));

`default_nettype wire

// File: tb_avionics_debug.sv
//******************************
// Testbench for the debug top level
// UART receiver model, reference lines,
// timeout and summary line
//******************************

`timescale 1ns/100ps
`default_nettype none

module tb_avionics_debug;

  localparam int STEP        = 500;
  localparam int CLK_PER_BIT = 4;
  localparam int NUM_LINES   = 6;
  // Six lines plus margin for the first tick
  localparam int TIMEOUT_CYCLES = 8 * STEP + STEP;

  logic       clk_debug;
  logic       rst;
  logic [7:0] status;
  logic       tx;
  logic       busy;

  integer     seed;
  logic [7:0] next_status;
  // Status held at tick n sits at index n-1
  logic [7:0] status_log [$];
  logic [7:0] rx_line  [debug_pkg::MSG_CHARS];
  logic [7:0] exp_line [debug_pkg::MSG_CHARS];
  int         tb_errors = 0;
  int         lines_rx  = 0;

  avionics_debug #(.STEP(STEP), .CLK_PER_BIT(CLK_PER_BIT)) u_dut (
    .clk_debug(clk_debug), .rst(rst), .status(status), .tx(tx), .busy(busy));

  task automatic value_error(input string test, input int line_no, input int exp, input int act);
    tb_errors++;
    $display("** Error %s, line %0d: expected 0x%0h, actual 0x%0h", test, line_no, exp, act);
  endtask

  // Reference text for tick n, stamp shown as n/10 with one decimal
  task automatic build_expected(input int n, input logic [7:0] st);
    string digits;
    string hex_set;
    hex_set = "0123456789ABCDEF";
    digits  = $sformatf("%05d", n % (1 << debug_pkg::STAMP_W));
    for (int i = 0; i < 4; i++) begin
      exp_line[i] = digits[i];
    end
    exp_line[4] = ".";
    exp_line[5] = digits[4];
    exp_line[6] = " ";
    // Upper-case hex, high nibble first
    exp_line[7] = hex_set[st[7:4]];
    exp_line[8] = hex_set[st[3:0]];
    exp_line[9] = 8'h0d;
  endtask

  // One 8N1 character, sampled mid-bit on the falling clock edge
  task automatic receive_char(input int line_no, input int pos);
    do @(negedge clk_debug); while (tx !== 1'b0);
    repeat (CLK_PER_BIT / 2) @(negedge clk_debug);
    assert (tx === 1'b0) else begin
      tb_errors++;
      $display("Start bit of character %0d on line %0d did not stay low", pos + 1, line_no);
    end
    for (int b = 0; b < 8; b++) begin
      repeat (CLK_PER_BIT) @(negedge clk_debug);
      rx_line[pos][b] = tx;
    end
    repeat (CLK_PER_BIT) @(negedge clk_debug);
    assert (tx === 1'b1) else begin
      tb_errors++;
      $display("Stop bit of character %0d on line %0d was not high", pos + 1, line_no);
    end
  endtask

  initial begin : clock_gen
    clk_debug = 1'b0;
    forever #20 clk_debug = ~clk_debug;
  end

  initial begin : stimulus
    seed   = 47;
    rst    = 1'b1;
    status = 8'h00;
    repeat (2) @(posedge clk_debug);
    rst <= 1'b0;
    @(negedge clk_debug);
    // Idle line after reset, {tx, busy} = 2'b10
    assert (tx === 1'b1 && busy === 1'b0)
      else value_error("reset state", 0, 2'b10, {tx, busy});
    // New status halfway between ticks, so it is stable at each capture
    repeat (STEP / 2) @(posedge clk_debug);
    repeat (NUM_LINES) begin
      next_status = 8'($random(seed));
      status <= next_status;
      status_log.push_back(next_status);
      repeat (STEP) @(posedge clk_debug);
    end
  end

  initial begin : receiver
    for (int n = 1; n <= NUM_LINES; n++) begin
      for (int c = 0; c < debug_pkg::MSG_CHARS; c++) begin
        receive_char(n, c);
      end
      build_expected(n, status_log[n-1]);
      // Line n carries stamp n, so a skipped or repeated line fails here
      for (int c = 0; c < debug_pkg::MSG_CHARS; c++) begin
        assert (rx_line[c] === exp_line[c])
          else value_error((c < 6) ? "timestamp" : (c == 6) ? "space" :
                           (c < 9) ? "status" : "carriage return",
                           n, exp_line[c], rx_line[c]);
      end
      lines_rx = n;
    end
  end

  initial begin : run_control
    int cycles;
    int chk_errors;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES && lines_rx < NUM_LINES) begin
      @(posedge clk_debug);
      cycles++;
    end
    if (lines_rx < NUM_LINES) begin
      tb_errors++;
      $display("Timeout after %0d cycles, only %0d of %0d lines received",
               cycles, lines_rx, NUM_LINES);
    end else begin
      // Room for the busy length check of the last line
      repeat (10) @(posedge clk_debug);
    end
    chk_errors = u_dut.u_checker.fail_count;
    $display("Errors: %0d testbench, %0d checker, %0d lines received",
             tb_errors, chk_errors, lines_rx);
    if (tb_errors == 0 && chk_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
debug_pkg.sv
stamp_counter.sv
bin2bcd.sv
status_hex.sv
msg_assembler.sv
serial_debug.sv
avionics_debug.sv
avionics_debug_checker.sv
tb_avionics_debug.sv

// File: Bender.yml
package:
  name: avionics_debug

sources:
  - debug_pkg.sv
  - stamp_counter.sv
  - bin2bcd.sv
  - status_hex.sv
  - msg_assembler.sv
  - serial_debug.sv
  - avionics_debug.sv
  - target: test
    files:
      - avionics_debug_checker.sv
      - tb_avionics_debug.sv
